//--- flist.f
+incdir+include
rtl/vlane_pkg.sv
rtl/vlane_decode.sv
rtl/vlane_execute.sv
rtl/vlane_result.sv
rtl/vlane_group.sv
test/tb_vlane_group.sv

//--- include/vlane_defines.svh
`ifndef VLANE_DEFINES_SVH
`define VLANE_DEFINES_SVH

// Lanes in one group
`define VLANE_NUM 4

// Bits carried per lane
`define LANE_W 8

// Bits in a whole group word
`define GROUP_W (`VLANE_NUM * `LANE_W)

// ALU opcode and immediate fields
`define OPMODE_W 3
`define IMM_W 5

`endif

//--- rtl/vlane_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "vlane_defines.svh"

module vlane_decode (
   input  wire logic                   clk_i,
   input  wire logic                   rst_i,
   input  wire logic                   advance_i,     // Stage enable from result
   input  wire logic                   cmd_valid_i,
   input  wire vlane_pkg::vlane_cmd_t  cmd_i,
   input  wire vlane_pkg::lane_bytes_t vs1_i,
   input  wire vlane_pkg::lane_bytes_t vs2_i,
   output logic                        dec_valid_o,
   output vlane_pkg::exec_bundle_t     dec_o
);

   import vlane_pkg::*;

   logic [`GROUP_W-1:0] imm_sext;
   elem_group_u         x_rep;
   elem_group_u         imm_rep;
   elem_group_u         op_b;
   exec_bundle_t        dec_d;

   // Repeat the low SEW bits of v into every element
   function automatic elem_group_u splat(input sew_e sew, input logic [`GROUP_W-1:0] v);
      elem_group_u g;
      case (sew)
         SEW8:    g.bytes = {`VLANE_NUM{v[`LANE_W-1:0]}};
         SEW16:   g.half  = {(`VLANE_NUM/2){v[2*`LANE_W-1:0]}};
         default: g.word  = v;                   // SEW32 and reserved
      endcase
      return g;
   endfunction

   //////////////////////////////////////////////////
   // Second operand

   // Sign extension to the full word, truncated again per element by splat
   assign imm_sext = {{(`GROUP_W-`IMM_W){cmd_i.imm[`IMM_W-1]}}, cmd_i.imm};

   assign x_rep   = splat(cmd_i.sew, cmd_i.x_data);
   assign imm_rep = splat(cmd_i.sew, imm_sext);

   always_comb
   begin
      case (cmd_i.op2_sel)
         OP2_VX:  op_b = x_rep;
         OP2_VI:  op_b = imm_rep;
         default: op_b.bytes = vs2_i;            // VV, also code 3
      endcase
   end

   //////////////////////////////////////////////////
   // Gather lanes into the operand groups

   always_comb
   begin
      dec_d.opcode     = cmd_i.opcode;
      dec_d.sew        = cmd_i.sew;
      dec_d.op_a.bytes = vs1_i;                  // Lane k is byte k of every view
      dec_d.op_b       = op_b;
   end

   //////////////////////////////////////////////////
   // Stage register

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         dec_valid_o <= 1'b0;
      end
      else if (advance_i)
      begin
         dec_valid_o <= cmd_valid_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (advance_i)
      begin
         dec_o <= dec_d;
      end
   end

endmodule

`default_nettype wire

//--- rtl/vlane_execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "vlane_defines.svh"

module vlane_execute (
   input  wire logic                    clk_i,
   input  wire logic                    rst_i,
   input  wire logic                    advance_i,
   input  wire logic                    dec_valid_i,
   input  wire vlane_pkg::exec_bundle_t dec_i,
   output logic                         exe_valid_o,
   output vlane_pkg::result_bundle_t    exe_o
);

   import vlane_pkg::*;

   elem_group_u             r8;
   elem_group_u             r16;
   elem_group_u             r32;
   logic [`VLANE_NUM-1:0]   eq8;
   logic [`VLANE_NUM/2-1:0] eq16;
   logic                    eq32;
   result_bundle_t          exe_d;

   // Operands come in zero extended, the caller keeps the low SEW bits
   function automatic logic [`GROUP_W-1:0] alu_elem(input alu_op_e op,
                                                    input logic [`GROUP_W-1:0] a,
                                                    input logic [`GROUP_W-1:0] b);
      case (op)
         ALU_ADD:  return a + b;
         ALU_SUB:  return a - b;
         ALU_AND:  return a & b;
         ALU_OR:   return a | b;
         ALU_XOR:  return a ^ b;
         ALU_MAXU: return (a > b) ? a : b;
         default:  return '0;                    // SEQ and opcode 7
      endcase
   endfunction

   //////////////////////////////////////////////////
   // One ALU per element in each view

   always_comb
   begin : alu_views
      logic [`GROUP_W-1:0] t;

      for (int j = 0; j < `VLANE_NUM; j++)
      begin
         t = alu_elem(dec_i.opcode,
                      {{(`GROUP_W-`LANE_W){1'b0}}, dec_i.op_a.bytes[j]},
                      {{(`GROUP_W-`LANE_W){1'b0}}, dec_i.op_b.bytes[j]});
         r8.bytes[j] = t[`LANE_W-1:0];
         eq8[j]      = (dec_i.op_a.bytes[j] == dec_i.op_b.bytes[j]);
      end

      for (int j = 0; j < `VLANE_NUM/2; j++)
      begin
         t = alu_elem(dec_i.opcode,
                      {{(`GROUP_W-2*`LANE_W){1'b0}}, dec_i.op_a.half[j]},
                      {{(`GROUP_W-2*`LANE_W){1'b0}}, dec_i.op_b.half[j]});
         r16.half[j] = t[2*`LANE_W-1:0];
         eq16[j]     = (dec_i.op_a.half[j] == dec_i.op_b.half[j]);
      end

      r32.word = alu_elem(dec_i.opcode, dec_i.op_a.word, dec_i.op_b.word);
      eq32     = (dec_i.op_a.word == dec_i.op_b.word);
   end

   // Pick the view for this SEW, 3 falls through to 32-bit
   always_comb
   begin
      exe_d.sew = dec_i.sew;
      case (dec_i.sew)
         SEW8:
         begin
            exe_d.res  = r8;
            exe_d.mask = eq8;
         end
         SEW16:
         begin
            exe_d.res  = r16;
            exe_d.mask = {{(`VLANE_NUM/2){1'b0}}, eq16};
         end
         default:
         begin
            exe_d.res  = r32;
            exe_d.mask = {{(`VLANE_NUM-1){1'b0}}, eq32};
         end
      endcase
      if (dec_i.opcode != ALU_SEQ)
         exe_d.mask = '0;                        // Mask only for compares
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         exe_valid_o <= 1'b0;
      else if (advance_i)
         exe_valid_o <= dec_valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (advance_i)
         exe_o <= exe_d;
   end

endmodule

`default_nettype wire

//--- rtl/vlane_group.sv
`timescale 1ns/1ps
`default_nettype none
`include "vlane_defines.svh"

module vlane_group (
   input  wire logic                   clk_i,
   input  wire logic                   rst_i,
   input  wire logic                   cmd_valid_i,
   output logic                        cmd_ready_o,
   input  wire vlane_pkg::vlane_cmd_t  cmd_i,
   input  wire vlane_pkg::lane_bytes_t vs1_i,
   input  wire vlane_pkg::lane_bytes_t vs2_i,
   output logic                        res_valid_o,
   input  wire logic                   res_ready_i,
   output vlane_pkg::lane_bytes_t      res_data_o,
   output logic [`VLANE_NUM-1:0]       res_mask_o
);

   import vlane_pkg::*;

   logic           advance;     // Shared stall enable, low while output is blocked
   logic           dec_valid;
   exec_bundle_t   dec_bundle;
   logic           exe_valid;
   result_bundle_t exe_bundle;

   assign cmd_ready_o = advance;

   vlane_decode u_decode (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .advance_i   (advance),
      .cmd_valid_i (cmd_valid_i),
      .cmd_i       (cmd_i),
      .vs1_i       (vs1_i),
      .vs2_i       (vs2_i),
      .dec_valid_o (dec_valid),
      .dec_o       (dec_bundle)
   );

   vlane_execute u_execute (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .advance_i   (advance),
      .dec_valid_i (dec_valid),
      .dec_i       (dec_bundle),
      .exe_valid_o (exe_valid),
      .exe_o       (exe_bundle)
   );

   vlane_result u_result (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .exe_valid_i (exe_valid),
      .exe_i       (exe_bundle),
      .res_ready_i (res_ready_i),
      .advance_o   (advance),
      .res_valid_o (res_valid_o),
      .res_data_o  (res_data_o),
      .res_mask_o  (res_mask_o)
   );

endmodule

`default_nettype wire

//--- rtl/vlane_pkg.sv
`default_nettype none
`include "vlane_defines.svh"

package vlane_pkg;

   // Element width, 3 is treated as 32-bit
   typedef enum logic [1:0] {
      SEW8    = 2'd0,
      SEW16   = 2'd1,
      SEW32   = 2'd2,
      SEW_RSV = 2'd3
   } sew_e;

   typedef enum logic [`OPMODE_W-1:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,   // a minus b
      ALU_AND  = 3'd2,
      ALU_OR   = 3'd3,
      ALU_XOR  = 3'd4,
      ALU_MAXU = 3'd5,
      ALU_SEQ  = 3'd6    // Mask only
   } alu_op_e;

   typedef enum logic [1:0] {
      OP2_VV = 2'd0,
      OP2_VX = 2'd1,
      OP2_VI = 2'd2
   } op2_sel_e;

   // Lane k holds byte k
   typedef logic [`VLANE_NUM-1:0][`LANE_W-1:0] lane_bytes_t;

   // One group word seen as a word, two halves or four bytes
   typedef union packed {
      logic [`GROUP_W-1:0]                   word;
      logic [`VLANE_NUM/2-1:0][2*`LANE_W-1:0] half;   // Half j on lanes 2j, 2j+1
      logic [`VLANE_NUM-1:0][`LANE_W-1:0]     bytes;
   } elem_group_u;

   typedef struct packed {
      alu_op_e             opcode;
      sew_e                sew;
      op2_sel_e            op2_sel;
      logic [`GROUP_W-1:0] x_data;
      logic [`IMM_W-1:0]   imm;
   } vlane_cmd_t;

   typedef struct packed {
      alu_op_e     opcode;
      sew_e        sew;
      elem_group_u op_a;
      elem_group_u op_b;
   } exec_bundle_t;

   typedef struct packed {
      sew_e                  sew;
      elem_group_u           res;
      logic [`VLANE_NUM-1:0] mask;   // One bit per element, low bits only
   } result_bundle_t;

endpackage

`default_nettype wire

//--- rtl/vlane_result.sv
`timescale 1ns/1ps
`default_nettype none
`include "vlane_defines.svh"

module vlane_result (
   input  wire logic                      clk_i,
   input  wire logic                      rst_i,
   input  wire logic                      exe_valid_i,
   input  wire vlane_pkg::result_bundle_t exe_i,
   input  wire logic                      res_ready_i,
   output logic                           advance_o,
   output logic                           res_valid_o,
   output vlane_pkg::lane_bytes_t         res_data_o,
   output logic [`VLANE_NUM-1:0]          res_mask_o
);

   import vlane_pkg::*;

   result_bundle_t res_q;

   // Empty or draining this cycle
   assign advance_o = !res_valid_o || res_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         res_valid_o <= 1'b0;
      else if (advance_o)
         res_valid_o <= exe_valid_i;
   end

   // Held while the consumer stalls
   always_ff @(posedge clk_i)
   begin
      if (advance_o)
         res_q <= exe_i;
   end

   //////////////////////////////////////////////////
   // Scatter back to the lanes

   assign res_data_o = res_q.res.bytes;

   // Each lane takes the bit of the element it belongs to
   always_comb
   begin
      for (int k = 0; k < `VLANE_NUM; k++)
      begin
         case (res_q.sew)
            SEW8:    res_mask_o[k] = res_q.mask[k];
            SEW16:   res_mask_o[k] = res_q.mask[k/2];
            default: res_mask_o[k] = res_q.mask[0];
         endcase
      end
   end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the vlane_group testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f flist.f \
   --top-module tb_vlane_group \
   -o vlane_sim

./obj_dir/vlane_sim | tee "$LOG"

if grep -q "sim failed" "$LOG"; then
   echo "Simulation reported a failure, see $LOG"
   exit 1
fi

//--- test/tb_vlane_group.sv
`timescale 1ns/1ps
`default_nettype none
`include "vlane_defines.svh"

module tb_vlane_group;

   import vlane_pkg::*;

   localparam logic [31:0] SEED        = 32'hc7c99465;
   localparam int          N_RANDOM    = 200;
   localparam int          WATCHDOG_NS = 500 * 20;   // 500 command cycles of 20 ns

   typedef struct packed {
      lane_bytes_t           data;
      logic [`VLANE_NUM-1:0] mask;
   } expect_t;

   logic                  clk_i;
   logic                  rst_i;
   logic                  cmd_valid_i;
   logic                  cmd_ready_o;
   vlane_cmd_t            cmd_i;
   lane_bytes_t           vs1_i;
   lane_bytes_t           vs2_i;
   logic                  res_valid_o;
   logic                  res_ready_i;
   lane_bytes_t           res_data_o;
   logic [`VLANE_NUM-1:0] res_mask_o;

   logic    accept;
   logic    consume;
   logic    hold_ready;
   logic    exp_empty;
   expect_t exp_front;
   expect_t exp_q[$];
   int      err_count = 0;
   int      end_errors = 0;
   int      n_checked = 0;

   vlane_group DUT (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_ready_o (cmd_ready_o),
      .cmd_i       (cmd_i),
      .vs1_i       (vs1_i),
      .vs2_i       (vs2_i),
      .res_valid_o (res_valid_o),
      .res_ready_i (res_ready_i),
      .res_data_o  (res_data_o),
      .res_mask_o  (res_mask_o)
   );

   assign accept  = cmd_valid_i && cmd_ready_o;
   assign consume = res_valid_o && res_ready_i;

   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   //////////////////////////////////////////////////
   // Reference model worked element by element

   function automatic expect_t model_result(input vlane_cmd_t c, input lane_bytes_t va,
                                            input lane_bytes_t vb);
      expect_t     e;
      int          nb;                          // Bytes per element
      logic        use_scal;
      logic [31:0] emask;
      logic [31:0] scal;
      logic [31:0] wa;
      logic [31:0] wb;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      logic [31:0] word;

      e = '0;
      word = 32'h0;
      wa = va;
      wb = vb;
      case (c.sew)
         SEW8:    nb = 1;
         SEW16:   nb = 2;
         default: nb = 4;
      endcase
      emask    = (nb == 4) ? 32'hFFFF_FFFF : ((32'd1 << (8 * nb)) - 32'd1);
      use_scal = (c.op2_sel == OP2_VX) || (c.op2_sel == OP2_VI);
      scal     = (c.op2_sel == OP2_VX) ? c.x_data : {{27{c.imm[4]}}, c.imm};
      for (int el = 0; el < 4 / nb; el++)
      begin
         a = (wa >> (8 * nb * el)) & emask;
         b = use_scal ? (scal & emask) : ((wb >> (8 * nb * el)) & emask);
         case (c.opcode)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_MAXU: r = (a > b) ? a : b;
            default:  r = 32'h0;                // SEQ and opcode 7
         endcase
         if (c.opcode == ALU_SEQ && a == b)
            for (int k = el * nb; k < (el + 1) * nb; k++)
               e.mask[k] = 1'b1;
         word = word | ((r & emask) << (8 * nb * el));
      end
      e.data = word;
      return e;
   endfunction

   function automatic vlane_cmd_t make_cmd(input alu_op_e op, input sew_e sew,
                                           input op2_sel_e sel, input logic [31:0] x,
                                           input logic [4:0] imm);
      vlane_cmd_t c;
      c.opcode  = op;
      c.sew     = sew;
      c.op2_sel = sel;
      c.x_data  = x;
      c.imm     = imm;
      return c;
   endfunction

   // Hold the command until the DUT takes it
   task automatic send_cmd(input vlane_cmd_t c, input lane_bytes_t a, input lane_bytes_t b);
      cmd_i       = c;
      vs1_i       = a;
      vs2_i       = b;
      cmd_valid_i = 1'b1;
      @(posedge clk_i);
      while (!cmd_ready_o)
         @(posedge clk_i);
      #1;
      cmd_valid_i = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk_i);
         #1;
      end
   endtask

   // Consumer stalls at random unless held ready
   always @(posedge clk_i)
   begin : ready_drive
      logic hold;
      hold = hold_ready;
      #1;
      res_ready_i = hold ? 1'b1 : ($urandom_range(3, 0) != 0);
   end

   always @(posedge clk_i)
   begin : scoreboard
      if (!rst_i)
      begin
         exp_q.delete();
         exp_empty <= 1'b1;
      end
      else
      begin
         if (consume && exp_q.size() != 0)
         begin
            exp_q.delete(0);
            n_checked++;
         end
         if (accept)
            exp_q.push_back(model_result(cmd_i, vs1_i, vs2_i));
         exp_empty <= (exp_q.size() == 0);
         if (exp_q.size() != 0)
            exp_front <= exp_q[0];                // Seen by the checks at the next edge
      end
   end

   //////////////////////////////////////////////////
   // Checks

   reset_idle: assert property (@(posedge clk_i) !rst_i |=> (!res_valid_o && cmd_ready_o))
      else begin
         err_count = err_count + 1;
         $display("FAILED %0t: outputs not idle after reset", $time);
      end

   no_extra_result: assert property (@(posedge clk_i) disable iff (!rst_i)
                                     consume |-> !exp_empty)
      else begin
         err_count = err_count + 1;
         $display("FAILED %0t: result with no command behind it", $time);
      end

   result_value: assert property (@(posedge clk_i) disable iff (!rst_i)
      (consume && !exp_empty) |-> (res_data_o == exp_front.data && res_mask_o == exp_front.mask))
      else begin
         err_count = err_count + 1;
         $display("FAILED %0t: got %h/%b, expected %h/%b", $time, res_data_o, res_mask_o,
                  exp_front.data, exp_front.mask);
      end

   stall_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
      (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_data_o)
                                         && $stable(res_mask_o)))
      else begin
         err_count = err_count + 1;
         $display("FAILED %0t: result changed while stalled", $time);
      end

   stall_blocks_input: assert property (@(posedge clk_i) disable iff (!rst_i)
      (res_valid_o && !res_ready_i) |-> !cmd_ready_o)
      else begin
         err_count = err_count + 1;
         $display("FAILED %0t: cmd_ready_o high during a stall", $time);
      end

   // Open at N, N+1 and N+2 so res_valid_o at N+3 follows the accept at N
   result_latency: assert property (@(posedge clk_i) disable iff (!rst_i)
      ($past(cmd_ready_o, 2) && $past(cmd_ready_o) && cmd_ready_o)
      |=> (res_valid_o == $past(accept, 3)))
      else begin
         err_count = err_count + 1;
         $display("FAILED %0t: result valid does not follow the accept three cycles before",
                  $time);
      end

   initial
   begin : watchdog
      #(WATCHDOG_NS);
      $display("Timeout: test did not finish within %0d ns", WATCHDOG_NS);
      $display("sim failed");
      $finish;
   end

   //////////////////////////////////////////////////
   // Stimulus

   initial
   begin : main
      vlane_cmd_t  c;
      lane_bytes_t a;
      lane_bytes_t b;
      logic [31:0] rnd;
      int          wait_cycles;

      void'($urandom(SEED));
      rst_i       = 1'b0;
      cmd_valid_i = 1'b0;
      cmd_i       = '0;
      vs1_i       = '0;
      vs2_i       = '0;
      res_ready_i = 1'b0;
      hold_ready  = 1'b1;
      repeat (5) @(posedge clk_i);
      #1;
      rst_i = 1'b1;

      // Directed cases back to back with the consumer always ready
      send_cmd(make_cmd(ALU_ADD, SEW8, OP2_VV, 32'h0, 5'h0), 32'hFFFF_FFFF, 32'h0101_0101);
      send_cmd(make_cmd(ALU_ADD, SEW16, OP2_VV, 32'h0, 5'h0), 32'hFFFF_FFFF, 32'h0001_0001);
      send_cmd(make_cmd(ALU_ADD, SEW32, OP2_VV, 32'h0, 5'h0), 32'hFFFF_FFFF, 32'h0000_0001);
      send_cmd(make_cmd(ALU_SUB, SEW8, OP2_VV, 32'h0, 5'h0), 32'h0000_0000, 32'h0101_0101);
      send_cmd(make_cmd(ALU_ADD, SEW8, OP2_VI, 32'h0, 5'h10), 32'h1234_5678, 32'h0);
      send_cmd(make_cmd(ALU_ADD, SEW16, OP2_VI, 32'h0, 5'h1F), 32'h1234_5678, 32'h0);
      send_cmd(make_cmd(ALU_ADD, SEW32, OP2_VI, 32'h0, 5'h15), 32'h1234_5678, 32'h0);
      send_cmd(make_cmd(ALU_XOR, SEW8, OP2_VX, 32'hABCD_EF12, 5'h0), 32'hFF00_FF00, 32'h0);
      send_cmd(make_cmd(ALU_OR, SEW16, OP2_VX, 32'h1234_5A5A, 5'h0), 32'h0F0F_0000, 32'h0);
      send_cmd(make_cmd(ALU_SEQ, SEW8, OP2_VV, 32'h0, 5'h0), 32'h1122_3344, 32'h1100_3344);
      send_cmd(make_cmd(ALU_SEQ, SEW16, OP2_VI, 32'h0, 5'h1F), 32'hFFFF_1234, 32'h0);
      send_cmd(make_cmd(ALU_SEQ, SEW32, OP2_VX, 32'hDEAD_BEEF, 5'h0), 32'hDEAD_BEEF, 32'h0);
      send_cmd(make_cmd(ALU_MAXU, SEW16, OP2_VV, 32'h0, 5'h0), 32'h8000_0001, 32'h7FFF_FFFF);
      send_cmd(make_cmd(ALU_AND, SEW_RSV, OP2_VV, 32'h0, 5'h0), 32'hF0F0_1234, 32'hFF00_FFFF);
      send_cmd(make_cmd(alu_op_e'(3'd7), SEW8, OP2_VV, 32'h0, 5'h0), 32'h1111_1111, 32'h1111_1111);

      hold_ready = 1'b0;
      for (int i = 0; i < N_RANDOM; i++)
      begin
         rnd       = $urandom;
         c.opcode  = alu_op_e'(rnd[2:0]);
         c.sew     = sew_e'(rnd[4:3]);
         c.op2_sel = op2_sel_e'(rnd[6:5]);
         c.imm     = rnd[11:7];
         c.x_data  = $urandom;
         a         = $urandom;
         b         = $urandom;
         if (rnd[13:12] == 2'd0)
            b = a;                               // Equal elements for SEQ
         else if (rnd[13:12] == 2'd1)
         begin
            b    = a;
            b[1] = ~a[1];
         end
         if (rnd[15:14] == 2'd0)
            c.x_data = a;
         send_cmd(c, a, b);
         idle_cycles(rnd[16] ? 1 : 0);
      end

      // Drain what is still in flight
      hold_ready  = 1'b1;
      wait_cycles = 0;
      while (exp_q.size() != 0 && wait_cycles < 20)
      begin
         @(posedge clk_i);
         wait_cycles++;
      end
      idle_cycles(4);
      if (exp_q.size() != 0)
      begin
         end_errors = end_errors + 1;
         $display("Results lost: %0d expected results never came out", exp_q.size());
      end

      $display("Results checked: %0d, errors: %0d", n_checked, err_count + end_errors);
      if (err_count + end_errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire
